/* dmr_pkg.sv */
// shared definitions for the dmr stream stage
// data width is only a default, every module takes DATA_BITS as a parameter
// the counter data wraps at 2**DATA_BITS, which is legal
package dmr_pkg;

    // default width of the counter data
    parameter int unsigned DATA_BITS_DEF = 8;

    // width of the detected-fault counter, saturates at the top
    parameter int unsigned FAULT_CNT_BITS = 8;

    // recovery control states
    typedef enum logic [1:0] {
        // normal operation
        CTRL_RUN    = 2'd0,
        // stage flush and source replay, one cycle
        CTRL_FLUSH  = 2'd1,
        // source gated for one cycle while it re-raises valid
        CTRL_REFILL = 2'd2
    } ctrl_state_e;

endpackage

/* seq_source.sv */
// deterministic counter source, emits 0, 1, 2, ... with valid/ready
// valid rises one cycle after next_item_i, a transfer needs allow_i as well
// replay_i rewinds the counter by one and re-raises valid
// a next_item_i still pending when a replay arrives is merged into the replay
`timescale 1ns/1ns

module seq_source #(
    parameter int unsigned DATA_BITS = dmr_pkg::DATA_BITS_DEF
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 next_item_i,
    input  logic                 allow_i,
    input  logic                 replay_i,
    input  logic                 ready_i,
    output logic                 valid_o,
    output logic [DATA_BITS-1:0] data_o
);

    logic [DATA_BITS-1:0] data_d, data_q;
    logic                 valid_d, valid_q;
    logic                 xfer;

    assign valid_o = valid_q;
    assign data_o  = data_q;
    // blocked handshakes do not count
    assign xfer    = valid_q & ready_i & allow_i;

    always_comb begin
        data_d  = data_q;
        valid_d = valid_q;
        // item taken, move to the next value
        if (xfer) begin
            valid_d = 1'b0;
            data_d  = data_q + 1'b1;
        end
        // request for one more item
        if (next_item_i) begin
            valid_d = 1'b1;
        end
        // lost item downstream, step back and offer it again
        if (replay_i) begin
            data_d  = data_q - 1'b1;
            valid_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            data_q  <= data_d;
            valid_q <= valid_d;
        end
    end

    // replay only while transfers are gated off
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        replay_i |-> !allow_i)
        else $error("seq_source: replay while transfers are allowed");

endmodule

/* dmr_stream_reg.sv */
// one-entry stream register held in two copies, primary and shadow
// output data is the primary copy, mismatch_o compares both copies
// fault_i flips bit 0 of the shadow data while the entry is held
// detection only, no voting, recovery is up to the control
`timescale 1ns/1ns

module dmr_stream_reg #(
    parameter int unsigned DATA_BITS = dmr_pkg::DATA_BITS_DEF
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // upstream side
    input  logic                 valid_i,
    input  logic [DATA_BITS-1:0] data_i,
    output logic                 ready_o,
    input  logic                 allow_in_i,
    // downstream side
    output logic                 valid_o,
    output logic [DATA_BITS-1:0] data_o,
    input  logic                 ready_i,
    input  logic                 allow_out_i,
    // recovery and test
    input  logic                 flush_i,
    input  logic                 fault_i,
    output logic                 mismatch_o
);

    logic [DATA_BITS-1:0] data_p_q, data_s_q;
    logic                 valid_p_q, valid_s_q;
    logic                 in_xfer, out_xfer;
    logic                 inject;

    // ready exactly when empty
    assign ready_o  = ~valid_p_q;
    assign valid_o  = valid_p_q;
    assign data_o   = data_p_q;
    assign in_xfer  = valid_i & ready_o & allow_in_i;
    assign out_xfer = valid_p_q & ready_i & allow_out_i;
    // only an entry that stays put gets corrupted
    assign inject   = fault_i & valid_s_q & ~out_xfer & ~flush_i;

    // disagreeing flags, or disagreeing data while holding
    assign mismatch_o = (valid_p_q != valid_s_q) |
                        (valid_p_q & (data_p_q != data_s_q));

    // valid copies
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_p_q <= 1'b0;
            valid_s_q <= 1'b0;
        end else if (flush_i || out_xfer) begin
            valid_p_q <= 1'b0;
            valid_s_q <= 1'b0;
        end else if (in_xfer) begin
            valid_p_q <= 1'b1;
            valid_s_q <= 1'b1;
        end
    end

    // data copies, both loaded from the same input
    always_ff @(posedge clk_i) begin
        if (in_xfer) begin
            data_p_q <= data_i;
            data_s_q <= data_i;
        end else if (inject) begin
            data_s_q[0] <= ~data_s_q[0];
        end
    end

    // flush only follows a mismatch on a held entry
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> (valid_p_q && $past(mismatch_o)))
        else $error("dmr_stream_reg: flush without a preceding mismatch");

    // a suspect entry never leaves the stage
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mismatch_o |-> !out_xfer)
        else $error("dmr_stream_reg: entry with mismatching copies was delivered");

endmodule

/* dmr_ctrl.sv */
// recovery control for the dmr stage
// a mismatch blocks the sink side, then flushes the stage and replays the source
// the source is gated during flush and for one refill cycle after it
// fault count saturates at all ones
`timescale 1ns/1ns

module dmr_ctrl (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                mismatch_i,
    output logic                                src_allow_o,
    output logic                                sink_allow_o,
    output logic                                flush_o,
    output logic                                replay_o,
    output logic [dmr_pkg::FAULT_CNT_BITS-1:0] fault_count_o
);

    import dmr_pkg::*;

    ctrl_state_e               state_d, state_q;
    logic [FAULT_CNT_BITS-1:0] fault_cnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_RUN: begin
                if (mismatch_i) begin
                    state_d = CTRL_FLUSH;
                end
            end
            CTRL_FLUSH:  state_d = CTRL_REFILL;
            CTRL_REFILL: state_d = CTRL_RUN;
            default:     state_d = CTRL_RUN;
        endcase
    end

    // never hand a suspect item to the sink
    assign sink_allow_o  = (state_q == CTRL_RUN) & ~mismatch_i;
    // source held off until the replayed item is settled
    assign src_allow_o   = (state_q == CTRL_RUN);
    assign flush_o       = (state_q == CTRL_FLUSH);
    assign replay_o      = (state_q == CTRL_FLUSH);
    assign fault_count_o = fault_cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= CTRL_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // one count per recovery, stick at the top
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fault_cnt_q <= '0;
        end else if (flush_o && (fault_cnt_q != '1)) begin
            fault_cnt_q <= fault_cnt_q + 1'b1;
        end
    end

    // the flush leaves the stage clean for the refill
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_o |=> !mismatch_i)
        else $error("dmr_ctrl: mismatch still present after flush");

endmodule

/* seq_sink.sv */
// ready-on-strobe sink, ready drops after each accepted item
// every accepted item is registered and marked by a one-cycle strobe_o
// order_error_o latches on any skipped, repeated or reordered item
// after an error the expected value resyncs to the received one
`timescale 1ns/1ns

module seq_sink #(
    parameter int unsigned DATA_BITS = dmr_pkg::DATA_BITS_DEF
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 raise_ready_i,
    input  logic                 allow_i,
    input  logic                 valid_i,
    input  logic [DATA_BITS-1:0] data_i,
    output logic                 ready_o,
    output logic                 strobe_o,
    output logic [DATA_BITS-1:0] data_o,
    output logic [31:0]          num_received_o,
    output logic                 order_error_o
);

    logic                 ready_q;
    logic                 xfer;
    logic                 strobe_q;
    logic [DATA_BITS-1:0] data_q;
    logic [DATA_BITS-1:0] expected_q;
    logic [31:0]          num_q;
    logic                 error_q;

    assign ready_o        = ready_q;
    assign xfer           = allow_i & valid_i & ready_q;
    assign strobe_o       = strobe_q;
    assign data_o         = data_q;
    assign num_received_o = num_q;
    assign order_error_o  = error_q;

    // control state and counters
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ready_q    <= 1'b0;
            strobe_q   <= 1'b0;
            expected_q <= '0;
            num_q      <= '0;
            error_q    <= 1'b0;
        end else begin
            // raise wins over the drop after a transfer
            if (raise_ready_i) begin
                ready_q <= 1'b1;
            end else if (xfer) begin
                ready_q <= 1'b0;
            end
            strobe_q <= xfer;
            if (xfer) begin
                num_q      <= num_q + 1'b1;
                expected_q <= data_i + 1'b1;
                if (data_i != expected_q) begin
                    error_q <= 1'b1;
                end
            end
        end
    end

    // received payload
    always_ff @(posedge clk_i) begin
        if (xfer) begin
            data_q <= data_i;
        end
    end

endmodule

/* dmr_top.sv */
// dmr stream stage between a counter source and an order-checking sink
// fault_i corrupts the shadow copy of a held item to provoke recovery
// latency from next_item_i to rx_strobe_o varies, rx_strobe_o marks delivery
`timescale 1ns/1ns

module dmr_top #(
    parameter int unsigned DATA_BITS = dmr_pkg::DATA_BITS_DEF
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                next_item_i,
    input  logic                                raise_ready_i,
    input  logic                                fault_i,
    output logic                                rx_strobe_o,
    output logic [DATA_BITS-1:0]                rx_data_o,
    output logic [31:0]                         num_received_o,
    output logic                                order_error_o,
    output logic [dmr_pkg::FAULT_CNT_BITS-1:0] fault_count_o
);

    // source to stage
    logic                 src_valid;
    logic [DATA_BITS-1:0] src_data;
    logic                 stage_in_ready;
    // stage to sink
    logic                 stage_valid;
    logic [DATA_BITS-1:0] stage_data;
    logic                 sink_ready;
    // control
    logic                 mismatch;
    logic                 src_allow, sink_allow;
    logic                 flush, replay;

    seq_source #(.DATA_BITS(DATA_BITS)) i_source (
        .clk_i, .rst_ni, .next_item_i,
        .allow_i (src_allow),
        .replay_i(replay),
        .ready_i (stage_in_ready),
        .valid_o (src_valid),
        .data_o  (src_data)
    );

    dmr_stream_reg #(.DATA_BITS(DATA_BITS)) i_stage (
        .clk_i, .rst_ni,
        .valid_i    (src_valid),
        .data_i     (src_data),
        .ready_o    (stage_in_ready),
        .allow_in_i (src_allow),
        .valid_o    (stage_valid),
        .data_o     (stage_data),
        .ready_i    (sink_ready),
        .allow_out_i(sink_allow),
        .flush_i    (flush),
        .fault_i,
        .mismatch_o (mismatch)
    );

    dmr_ctrl i_ctrl (
        .clk_i, .rst_ni,
        .mismatch_i  (mismatch),
        .src_allow_o (src_allow),
        .sink_allow_o(sink_allow),
        .flush_o     (flush),
        .replay_o    (replay),
        .fault_count_o
    );

    seq_sink #(.DATA_BITS(DATA_BITS)) i_sink (
        .clk_i, .rst_ni, .raise_ready_i,
        .allow_i       (sink_allow),
        .valid_i       (stage_valid),
        .data_i        (stage_data),
        .ready_o       (sink_ready),
        .strobe_o      (rx_strobe_o),
        .data_o        (rx_data_o),
        .num_received_o,
        .order_error_o
    );

endmodule

/* tb_clk_gen.sv */
// testbench clock and reset source
// clock period is 2 * HALF_PERIOD, reset low for RESET_CYCLES rising edges
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int unsigned HALF_PERIOD  = 5,
    parameter int unsigned RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // release away from the active edge
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

/* tb_dmr_top.sv */
// testbench for dmr_top, inputs driven and outputs sampled on the falling edge
// every rx strobe is checked against a counter model of the source data
// faults are only injected while the stage is known to hold an item
`timescale 1ns/1ns

module tb_dmr_top;

    import dmr_pkg::*;

    localparam int DATA_BITS    = DATA_BITS_DEF;
    localparam int RANDOM_CYCLES = 1000;
    localparam int BP_CYCLES    = 50;
    localparam int FAULT_ROUNDS = 10;
    // tests take about 1800 cycles, roughly doubled
    localparam int CYCLE_LIMIT  = 4000;

    logic                      clk, rst_n;
    logic                      next_item, raise_ready, fault;
    logic                      rx_strobe, order_error;
    logic [DATA_BITS-1:0]      rx_data;
    logic [31:0]               num_received;
    logic [FAULT_CNT_BITS-1:0] fault_count;

    // model state
    logic [DATA_BITS-1:0] exp_data;
    int                   strobe_count, faults_injected;
    bit                   strobe_now, order_err_seen;
    int                   error_count, check_count, tests_passed, tests_failed;
    int                   cycles, errs_start, strobes_before;
    integer               seed;
    logic [31:0]          r;

    tb_clk_gen #(.HALF_PERIOD(5), .RESET_CYCLES(4)) i_clk_gen (
        .clk_o (clk),
        .rst_no(rst_n)
    );

    dmr_top #(.DATA_BITS(DATA_BITS)) uut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .next_item_i   (next_item),
        .raise_ready_i (raise_ready),
        .fault_i       (fault),
        .rx_strobe_o   (rx_strobe),
        .rx_data_o     (rx_data),
        .num_received_o(num_received),
        .order_error_o (order_error),
        .fault_count_o (fault_count)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // one cycle, outputs sampled at the falling edge, strobes go through the model
    task automatic step();
        @(negedge clk);
        strobe_now = rx_strobe;
        if (rx_strobe) begin
            check_value("rx_data", rx_data, exp_data);
            exp_data = exp_data + 1'b1;
            strobe_count++;
        end
        if (order_error) begin
            order_err_seen = 1'b1;
        end
    endtask

    task automatic pulse_next_item();
        next_item = 1'b1;
        step();
        next_item = 1'b0;
    endtask

    task automatic wait_for_strobe(input int max_cycles);
        int n;
        n = 0;
        strobe_now = 1'b0;
        while (!strobe_now && n < max_cycles) begin
            step();
            n++;
        end
        if (!strobe_now) begin
            error_count++;
            $display("no strobe within %0d cycles after ready was raised", max_cycles);
        end
    endtask

    // leaves the sink ready low, a pending ready is used up by one extra item
    task automatic quiesce();
        raise_ready = 1'b0;
        next_item   = 1'b0;
        repeat (10) step();
        pulse_next_item();
        repeat (10) step();
    endtask

    task automatic report_test(input int num, input string name);
        if (error_count == errs_start) begin
            tests_passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", num, name, error_count - errs_start);
        end
        errs_start = error_count;
    endtask

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        next_item       = 1'b0;
        raise_ready     = 1'b0;
        fault           = 1'b0;
        seed            = 32'h4432;
        exp_data        = '0;
        strobe_count    = 0;
        faults_injected = 0;
        order_err_seen  = 1'b0;
        error_count     = 0;
        check_count     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        errs_start      = 0;
        wait (rst_n);

        // reset values
        step();
        check_value("rx_strobe after reset", rx_strobe, 0);
        check_value("num_received after reset", num_received, 0);
        check_value("fault_count after reset", fault_count, 0);
        check_value("order_error after reset", order_error, 0);
        report_test(1, "reset");

        // random requests and ready raises
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r           = $random(seed);
            next_item   = r[0];
            raise_ready = r[1];
            step();
        end
        check_value("any item delivered", strobe_count > 0, 1);
        report_test(2, "random in-order delivery");

        // sink held off, nothing may come through
        quiesce();
        strobes_before = strobe_count;
        for (int i = 0; i < BP_CYCLES; i++) begin
            next_item = (i % 5 == 0);
            step();
        end
        next_item = 1'b0;
        check_value("strobes under back-pressure", strobe_count, strobes_before);
        // ready back, one request every 4 cycles
        raise_ready = 1'b1;
        for (int i = 0; i < 32; i++) begin
            next_item = (i % 4 == 0);
            step();
        end
        next_item = 1'b0;
        repeat (8) step();
        check_value("items after ready returned", strobe_count >= strobes_before + 8, 1);
        report_test(3, "back-pressure");

        // shadow corruption on a held item, then replay
        for (int k = 0; k < FAULT_ROUNDS; k++) begin
            quiesce();
            pulse_next_item();
            repeat (3) step();
            strobes_before = strobe_count;
            fault = 1'b1;
            step();
            fault = 1'b0;
            faults_injected++;
            repeat (5) step();
            check_value("fault_count", fault_count, faults_injected);
            check_value("strobes during recovery", strobe_count, strobes_before);
            raise_ready = 1'b1;
            step();
            raise_ready = 1'b0;
            wait_for_strobe(20);
            repeat (5) step();
            check_value("strobes after recovery", strobe_count, strobes_before + 1);
        end
        report_test(4, "fault recovery");

        // totals against the model
        check_value("num_received", num_received, strobe_count);
        check_value("fault_count total", fault_count, faults_injected);
        check_value("order_error seen", order_err_seen, 0);
        report_test(5, "final totals");

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d, items %0d",
                 tests_passed, tests_failed, check_count, error_count, strobe_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
dmr_pkg.sv
seq_source.sv
dmr_stream_reg.sv
dmr_ctrl.sv
seq_sink.sv
dmr_top.sv
tb_clk_gen.sv
tb_dmr_top.sv
